// ==== datapath.f ====
src/cpu_pkg.sv
src/alu.sv
src/register_file.sv
src/control_unit.sv
src/hazard_unit.sv
src/stage_reg.sv
src/datapath.sv
tb/datapath_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run with verilator, verdict taken from the simulation log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f datapath.f --top-module datapath_tb \
  -Mdir obj_dir -o datapath_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/datapath_sim > sim.log 2>&1
cat sim.log
grep -q "Simulation failed" sim.log && exit 1
grep -q "Simulation completed successfully" sim.log || exit 1
exit 0

// ==== src/alu.sv ====
module alu import cpu_pkg::*; (
  input  alu_op_t    op,
  input  word_t      a,
  input  word_t      b,
  input  logic [4:0] shamt,
  output word_t      result,
  output logic       zero
);

  always_comb begin
    case (op)
      ALU_ADD: result = a + b;
      ALU_SUB: result = a - b;
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      ALU_SLT: begin
        // signed compare
        if ($signed(a) < $signed(b)) begin
          result = 32'd1;
        end else begin
          result = 32'd0;
        end
      end
      ALU_SLL: result = b << shamt;
      ALU_LUI: result = b;  // imm already shifted up
      default: result = '0;
    endcase
  end

  // branch compare uses sub
  assign zero = (result == '0);

endmodule

// ==== src/control_unit.sv ====
module control_unit import cpu_pkg::*; (
  input  word_t     instr,
  output alu_op_t   alu_op,
  output logic      alu_src,
  output imm_mode_t imm_mode,
  output logic      reg_dst_rd,
  output logic      reg_write,
  output logic      mem_read,
  output logic      mem_write,
  output logic      mem_to_reg,
  output logic      jump,
  output logic      halt,
  output branch_t   branch
);

  opcode_t opcode;
  funct_t  funct;

  assign opcode = opcode_t'(instr[31:26]);
  assign funct  = funct_t'(instr[5:0]);

  always_comb begin
    alu_op     = ALU_ADD;
    alu_src    = 1'b0;
    imm_mode   = IMM_SIGN;
    reg_dst_rd = 1'b0;
    reg_write  = 1'b0;
    mem_read   = 1'b0;
    mem_write  = 1'b0;
    mem_to_reg = 1'b0;
    jump       = 1'b0;
    halt       = 1'b0;
    branch     = BR_NONE;

    // all-zero word is a bubble, leave defaults
    if (instr != '0) begin
      case (opcode)
        OP_RTYPE: begin
          reg_dst_rd = 1'b1;
          reg_write  = 1'b1;
          case (funct)
            FN_ADDU: alu_op = ALU_ADD;
            FN_SUBU: alu_op = ALU_SUB;
            FN_AND:  alu_op = ALU_AND;
            FN_OR:   alu_op = ALU_OR;
            FN_SLT:  alu_op = ALU_SLT;
            FN_SLL:  alu_op = ALU_SLL;
            default: reg_write = 1'b0;  // unsupported funct
          endcase
        end
        OP_ADDIU: begin
          alu_src   = 1'b1;
          reg_write = 1'b1;
        end
        OP_ORI: begin
          alu_op    = ALU_OR;
          alu_src   = 1'b1;
          imm_mode  = IMM_ZERO;
          reg_write = 1'b1;
        end
        OP_LUI: begin
          alu_op    = ALU_LUI;
          alu_src   = 1'b1;
          imm_mode  = IMM_UPPER;
          reg_write = 1'b1;
        end
        OP_LW: begin
          alu_src    = 1'b1;
          mem_read   = 1'b1;
          mem_to_reg = 1'b1;
          reg_write  = 1'b1;
        end
        OP_SW: begin
          alu_src   = 1'b1;
          mem_write = 1'b1;
        end
        OP_BEQ: begin
          alu_op = ALU_SUB;
          branch = BR_EQ;
        end
        OP_BNE: begin
          alu_op = ALU_SUB;
          branch = BR_NE;
        end
        OP_J:    jump = 1'b1;
        OP_HALT: halt = 1'b1;
        default: ;
      endcase
    end
  end

endmodule

// ==== src/cpu_pkg.sv ====
package cpu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;

  // major opcodes in bits 31:26
  typedef enum logic [5:0] {
    OP_RTYPE = 6'h00,
    OP_J     = 6'h02,
    OP_BEQ   = 6'h04,
    OP_BNE   = 6'h05,
    OP_ADDIU = 6'h09,
    OP_ORI   = 6'h0d,
    OP_LUI   = 6'h0f,
    OP_LW    = 6'h23,
    OP_SW    = 6'h2b,
    OP_HALT  = 6'h3f
  } opcode_t;

  typedef enum logic [5:0] {
    FN_SLL  = 6'h00,
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_SLT  = 6'h2a
  } funct_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT,
    ALU_SLL,
    ALU_LUI   // passes b through
  } alu_op_t;

  typedef enum logic [1:0] {
    IMM_SIGN,
    IMM_ZERO,
    IMM_UPPER
  } imm_mode_t;

  typedef enum logic [1:0] {
    BR_NONE,
    BR_EQ,
    BR_NE
  } branch_t;

  typedef enum logic [1:0] {
    FWD_REG,
    FWD_EXMEM,
    FWD_WB
  } fwd_sel_t;

  typedef struct packed {
    word_t       pc4;
    logic [25:0] instr_idx;  // jump index field
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   dest;
    word_t       rdat1;
    word_t       rdat2;
    word_t       imm;
    alu_op_t     alu_op;
    logic [4:0]  shamt;
    logic        alu_src;
    branch_t     branch;
    logic        jump;
    logic        mem_read;
    logic        mem_write;
    logic        mem_to_reg;
    logic        reg_write;
    logic        halt;
  } idex_t;

  typedef struct packed {
    word_t     alu_result;
    word_t     store_data;
    reg_addr_t dest;
    logic      mem_read;
    logic      mem_write;
    logic      mem_to_reg;
    logic      reg_write;
    logic      halt;
  } exmem_t;

  typedef struct packed {
    word_t     alu_result;
    word_t     load_data;
    reg_addr_t dest;
    logic      mem_to_reg;
    logic      reg_write;
    logic      halt;
  } memwb_t;

endpackage

// ==== src/datapath.sv ====
module datapath import cpu_pkg::*; #(
  parameter word_t PC_INIT = '0
) (
  input  logic  CLK,
  input  logic  nRST,
  output word_t imem_addr,
  input  word_t imem_load,
  input  logic  ihit,
  output logic  dmem_ren,
  output logic  dmem_wen,
  output word_t dmem_addr,
  output word_t dmem_store,
  input  word_t dmem_load,
  output logic  halt
);

  typedef word_t [1:0] ifid_t;  // [1] instr, [0] pc + 4

  word_t     pc, pc_plus4, pc_next, target;
  ifid_t     ifid_d, ifid_q;
  word_t     instr, rdat1, rdat2, imm_ext, wdat;
  idex_t     idex_d, idex_q;
  exmem_t    exmem_d, exmem_q;
  memwb_t    memwb_d, memwb_q;
  alu_op_t   dec_alu_op;
  imm_mode_t dec_imm_mode;
  branch_t   dec_branch;
  logic      dec_alu_src, dec_reg_dst_rd, dec_reg_write, dec_mem_read;
  logic      dec_mem_write, dec_mem_to_reg, dec_jump, dec_halt;
  fwd_sel_t  fwd_a, fwd_b;
  word_t     op_a, op_b_fwd, op_b, alu_result;
  logic      alu_zero, branch_taken, take_branch;
  logic      pc_en, ifid_en, ifid_flush, idex_en, idex_flush, back_en;

  // fetch
  assign pc_plus4  = pc + 32'd4;
  assign imem_addr = pc;
  assign pc_next   = take_branch ? target : pc_plus4;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc <= PC_INIT;
    end else if (pc_en) begin
      pc <= pc_next;
    end
  end

  assign ifid_d = {imem_load, pc_plus4};

  stage_reg #(.T(ifid_t)) u_ifid (
    .CLK(CLK), .nRST(nRST), .en(ifid_en), .flush(ifid_flush), .d(ifid_d), .q(ifid_q)
  );

  // decode
  assign instr = ifid_q[1];

  control_unit u_ctrl (
    .instr(instr), .alu_op(dec_alu_op), .alu_src(dec_alu_src), .imm_mode(dec_imm_mode),
    .reg_dst_rd(dec_reg_dst_rd), .reg_write(dec_reg_write), .mem_read(dec_mem_read),
    .mem_write(dec_mem_write), .mem_to_reg(dec_mem_to_reg), .jump(dec_jump),
    .halt(dec_halt), .branch(dec_branch)
  );

  register_file u_rf (
    .CLK(CLK), .nRST(nRST), .rsel1(instr[25:21]), .rsel2(instr[20:16]),
    .rdat1(rdat1), .rdat2(rdat2), .wen(memwb_q.reg_write && back_en),
    .wsel(memwb_q.dest), .wdat(wdat)
  );

  always_comb begin
    case (dec_imm_mode)
      IMM_ZERO:  imm_ext = {16'h0000, instr[15:0]};
      IMM_UPPER: imm_ext = {instr[15:0], 16'h0000};
      default:   imm_ext = {{16{instr[15]}}, instr[15:0]};
    endcase
  end

  always_comb begin
    idex_d            = '0;
    idex_d.pc4        = ifid_q[0];
    idex_d.instr_idx  = instr[25:0];
    idex_d.rs         = instr[25:21];
    idex_d.rt         = instr[20:16];
    idex_d.dest       = dec_reg_dst_rd ? instr[15:11] : instr[20:16];
    idex_d.rdat1      = rdat1;
    idex_d.rdat2      = rdat2;
    idex_d.imm        = imm_ext;
    idex_d.alu_op     = dec_alu_op;
    idex_d.shamt      = instr[10:6];
    idex_d.alu_src    = dec_alu_src;
    idex_d.branch     = dec_branch;
    idex_d.jump       = dec_jump;
    idex_d.mem_read   = dec_mem_read;
    idex_d.mem_write  = dec_mem_write;
    idex_d.mem_to_reg = dec_mem_to_reg;
    idex_d.reg_write  = dec_reg_write;
    idex_d.halt       = dec_halt;
  end

  stage_reg #(.T(idex_t)) u_idex (
    .CLK(CLK), .nRST(nRST), .en(idex_en), .flush(idex_flush), .d(idex_d), .q(idex_q)
  );

  // execute
  hazard_unit u_hazard (
    .idex_rs(idex_q.rs), .idex_rt(idex_q.rt), .ifid_rs(instr[25:21]),
    .ifid_rt(instr[20:16]), .idex_dest(idex_q.dest), .exmem_dest(exmem_q.dest),
    .memwb_dest(memwb_q.dest), .idex_mem_read(idex_q.mem_read),
    .exmem_reg_write(exmem_q.reg_write), .memwb_reg_write(memwb_q.reg_write),
    .take_branch(take_branch), .ihit(ihit), .fwd_a(fwd_a), .fwd_b(fwd_b),
    .pc_en(pc_en), .ifid_en(ifid_en), .ifid_flush(ifid_flush), .idex_en(idex_en),
    .idex_flush(idex_flush), .back_en(back_en)
  );

  always_comb begin
    case (fwd_a)
      FWD_EXMEM: op_a = exmem_q.alu_result;
      FWD_WB:    op_a = wdat;
      default:   op_a = idex_q.rdat1;
    endcase
    case (fwd_b)
      FWD_EXMEM: op_b_fwd = exmem_q.alu_result;
      FWD_WB:    op_b_fwd = wdat;
      default:   op_b_fwd = idex_q.rdat2;
    endcase
  end

  assign op_b = idex_q.alu_src ? idex_q.imm : op_b_fwd;

  alu u_alu (
    .op(idex_q.alu_op), .a(op_a), .b(op_b), .shamt(idex_q.shamt),
    .result(alu_result), .zero(alu_zero)
  );

  assign branch_taken = (idex_q.branch == BR_EQ && alu_zero) ||
                        (idex_q.branch == BR_NE && !alu_zero);
  assign take_branch  = branch_taken || idex_q.jump;
  assign target = idex_q.jump ? {idex_q.pc4[31:28], idex_q.instr_idx, 2'b00}
                              : idex_q.pc4 + {idex_q.imm[29:0], 2'b00};

  assign exmem_d = '{alu_result: alu_result, store_data: op_b_fwd, dest: idex_q.dest,
                     mem_read: idex_q.mem_read, mem_write: idex_q.mem_write,
                     mem_to_reg: idex_q.mem_to_reg, reg_write: idex_q.reg_write,
                     halt: idex_q.halt};

  stage_reg #(.T(exmem_t)) u_exmem (
    .CLK(CLK), .nRST(nRST), .en(back_en), .flush(1'b0), .d(exmem_d), .q(exmem_q)
  );

  // memory stage gives one write strobe per store
  assign dmem_addr  = exmem_q.alu_result;
  assign dmem_store = exmem_q.store_data;
  assign dmem_ren   = exmem_q.mem_read;
  assign dmem_wen   = exmem_q.mem_write && back_en;

  assign memwb_d = '{alu_result: exmem_q.alu_result, load_data: dmem_load,
                     dest: exmem_q.dest, mem_to_reg: exmem_q.mem_to_reg,
                     reg_write: exmem_q.reg_write, halt: exmem_q.halt};

  stage_reg #(.T(memwb_t)) u_memwb (
    .CLK(CLK), .nRST(nRST), .en(back_en), .flush(1'b0), .d(memwb_d), .q(memwb_q)
  );

  // writeback
  assign wdat = memwb_q.mem_to_reg ? memwb_q.load_data : memwb_q.alu_result;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      halt <= 1'b0;
    end else if (memwb_q.halt) begin
      halt <= 1'b1;  // sticky until reset
    end
  end

endmodule

// ==== src/hazard_unit.sv ====
module hazard_unit import cpu_pkg::*; (
  input  reg_addr_t idex_rs,
  input  reg_addr_t idex_rt,
  input  reg_addr_t ifid_rs,
  input  reg_addr_t ifid_rt,
  input  reg_addr_t idex_dest,
  input  reg_addr_t exmem_dest,
  input  reg_addr_t memwb_dest,
  input  logic      idex_mem_read,
  input  logic      exmem_reg_write,
  input  logic      memwb_reg_write,
  input  logic      take_branch,
  input  logic      ihit,
  output fwd_sel_t  fwd_a,
  output fwd_sel_t  fwd_b,
  output logic      pc_en,
  output logic      ifid_en,
  output logic      ifid_flush,
  output logic      idex_en,
  output logic      idex_flush,
  output logic      back_en
);

  logic load_use;

  // newest producer wins
  function automatic fwd_sel_t pick_src(reg_addr_t src);
    if (exmem_reg_write && exmem_dest != '0 && exmem_dest == src) return FWD_EXMEM;
    if (memwb_reg_write && memwb_dest != '0 && memwb_dest == src) return FWD_WB;
    return FWD_REG;
  endfunction

  always_comb begin
    fwd_a = pick_src(idex_rs);
    fwd_b = pick_src(idex_rt);
  end

  assign load_use = idex_mem_read && (idex_dest != '0) &&
                    (idex_dest == ifid_rs || idex_dest == ifid_rt);

  always_comb begin
    back_en    = ihit;                                   // ex/mem and mem/wb
    idex_en    = ihit;
    pc_en      = ihit && (take_branch || !load_use);     // redirect beats stall
    ifid_en    = ihit && !load_use;
    ifid_flush = ihit && take_branch;
    idex_flush = ihit && (take_branch || load_use);      // bubble into ex
    if (take_branch) begin
      // a branch or jump in ex is never a load so no stall can hold the pc
      assert (!load_use);
    end
  end

endmodule

// ==== src/register_file.sv ====
module register_file import cpu_pkg::*; (
  input  logic      CLK,
  input  logic      nRST,
  input  reg_addr_t rsel1,
  input  reg_addr_t rsel2,
  output word_t     rdat1,
  output word_t     rdat2,
  input  logic      wen,
  input  reg_addr_t wsel,
  input  word_t     wdat
);

  word_t regs [32];
  logic  wr_live;

  assign wr_live = wen && (wsel != '0);  // r0 never written

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_live) begin
      regs[wsel] <= wdat;
    end
  end

  // same-cycle write shows up on the read ports
  assign rdat1 = (wr_live && wsel == rsel1) ? wdat : regs[rsel1];
  assign rdat2 = (wr_live && wsel == rsel2) ? wdat : regs[rsel2];

  // r0 reads as zero through storage and bypass alike
  a_r0_zero: assert property (@(posedge CLK) disable iff (!nRST)
    (rsel1 != '0 || rdat1 == '0) && (rsel2 != '0 || rdat2 == '0));

endmodule

// ==== src/stage_reg.sv ====
module stage_reg #(
  parameter type T = logic [31:0]
) (
  input  logic CLK,
  input  logic nRST,
  input  logic en,
  input  logic flush,
  input  T     d,
  output T     q
);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      q <= '0;
    end else if (flush) begin
      q <= '0;  // bubble
    end else if (en) begin
      q <= d;
    end
  end

  a_q_known: assert property (@(posedge CLK) disable iff (!nRST) !$isunknown(q));

endmodule

// ==== tb/datapath_tb.sv ====
module datapath_tb import cpu_pkg::*; ();

  localparam int NT = 6;    // tests in the table
  localparam int PW = 16;   // program words per test
  localparam int DW = 8;    // initial data words per test
  localparam int SMAX = 8;  // max expected stores per test
  localparam int WATCHDOG_CYCLES = NT * PW * 20;

  logic  CLK = 1'b0;
  logic  nRST;
  logic  ihit = 1'b1;
  word_t imem_addr, imem_load, dmem_addr, dmem_store, dmem_load;
  logic  dmem_ren, dmem_wen, halt;

  string test_name [NT];
  word_t prog      [NT][PW];
  int    plen      [NT];
  word_t dinit     [NT][DW];
  word_t exp_addr  [NT][SMAX];
  word_t exp_data  [NT][SMAX];
  int    exp_cnt   [NT];
  logic  rand_gaps [NT];

  word_t imem [64];
  word_t dmem [64];
  word_t seen_addr [$];
  word_t seen_data [$];
  int    cur = 0;
  word_t rng = 32'd62613;

  always #5 CLK = ~CLK;

  datapath #(.PC_INIT(32'h0)) u_dut (
    .CLK(CLK), .nRST(nRST), .imem_addr(imem_addr), .imem_load(imem_load), .ihit(ihit),
    .dmem_ren(dmem_ren), .dmem_wen(dmem_wen), .dmem_addr(dmem_addr),
    .dmem_store(dmem_store), .dmem_load(dmem_load), .halt(halt)
  );

  assign imem_load = imem[imem_addr[7:2]];
  assign dmem_load = dmem_ren ? dmem[dmem_addr[7:2]] : '0;  // same-cycle read

  function automatic word_t rtype_word(input int rs, input int rt, input int rd,
                                       input int sh, input funct_t fn);
    return {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
  endfunction

  function automatic word_t itype_word(input opcode_t op, input int rs, input int rt,
                                       input int imm);
    return {op, 5'(rs), 5'(rt), 16'(imm)};
  endfunction

  function automatic word_t jump_word(input int idx);
    return {OP_J, 26'(idx)};
  endfunction

  function automatic word_t xorshift(input word_t x);
    word_t y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic append_instr(input int t, input word_t w);
    prog[t][plen[t]] = w;
    plen[t]++;
  endtask

  task automatic expect_store(input int t, input word_t addr, input word_t data);
    exp_addr[t][exp_cnt[t]] = addr;
    exp_data[t][exp_cnt[t]] = data;
    exp_cnt[t]++;
  endtask

  task automatic build_table();
    for (int t = 0; t < NT; t++) begin
      plen[t] = 0;
      exp_cnt[t] = 0;
      rand_gaps[t] = 1'b0;
      for (int i = 0; i < PW; i++) prog[t][i] = '0;
      for (int i = 0; i < DW; i++) dinit[t][i] = '0;
    end
    // back-to-back alu dependencies
    test_name[0] = "rtype_chain";
    append_instr(0, itype_word(OP_ADDIU, 0, 1, 7));
    append_instr(0, itype_word(OP_ADDIU, 0, 2, 3));
    append_instr(0, rtype_word(1, 2, 3, 0, FN_ADDU));   // r3 = 10
    append_instr(0, rtype_word(3, 1, 4, 0, FN_SUBU));   // r4 = 3
    append_instr(0, rtype_word(4, 3, 5, 0, FN_AND));    // r5 = 2
    append_instr(0, rtype_word(5, 1, 6, 0, FN_OR));     // r6 = 7
    append_instr(0, rtype_word(2, 1, 9, 0, FN_SUBU));   // r9 = -4
    append_instr(0, rtype_word(9, 6, 7, 0, FN_SLT));    // r7 = 1 only when signed
    append_instr(0, rtype_word(0, 6, 8, 4, FN_SLL));    // r8 = 0x70
    append_instr(0, itype_word(OP_SW, 0, 8, 20));       // store data forwarded
    append_instr(0, itype_word(OP_SW, 0, 3, 0));
    append_instr(0, itype_word(OP_SW, 0, 4, 4));
    append_instr(0, itype_word(OP_SW, 0, 5, 8));
    append_instr(0, itype_word(OP_SW, 0, 6, 12));
    append_instr(0, itype_word(OP_SW, 0, 7, 16));
    append_instr(0, {OP_HALT, 26'd0});
    expect_store(0, 32'd20, 32'h70);
    expect_store(0, 32'd0, 32'd10);
    expect_store(0, 32'd4, 32'd3);
    expect_store(0, 32'd8, 32'd2);
    expect_store(0, 32'd12, 32'd7);
    expect_store(0, 32'd16, 32'd1);
    test_name[1] = "immediates";
    append_instr(1, itype_word(OP_LUI, 0, 1, 16'h1234));
    append_instr(1, itype_word(OP_ORI, 1, 1, 16'h5678));
    append_instr(1, itype_word(OP_ADDIU, 0, 2, -5));
    append_instr(1, itype_word(OP_ADDIU, 2, 3, 16));
    append_instr(1, itype_word(OP_ORI, 0, 4, 16'h8000)); // zero extended
    append_instr(1, itype_word(OP_SW, 0, 1, 0));
    append_instr(1, itype_word(OP_SW, 0, 2, 4));
    append_instr(1, itype_word(OP_SW, 0, 3, 8));
    append_instr(1, itype_word(OP_SW, 0, 4, 12));
    append_instr(1, {OP_HALT, 26'd0});
    expect_store(1, 32'd0, 32'h12345678);
    expect_store(1, 32'd4, 32'hfffffffb);
    expect_store(1, 32'd8, 32'h0000000b);
    expect_store(1, 32'd12, 32'h00008000);
    test_name[2] = "load_use";
    dinit[2][0] = 32'h00000064;
    dinit[2][1] = 32'h0000abcd;
    append_instr(2, itype_word(OP_ADDIU, 0, 1, 5));
    append_instr(2, itype_word(OP_LW, 0, 2, 0));
    append_instr(2, rtype_word(2, 1, 3, 0, FN_ADDU));   // needs the load so it stalls
    append_instr(2, itype_word(OP_SW, 0, 3, 8));
    append_instr(2, itype_word(OP_LW, 0, 4, 4));
    append_instr(2, itype_word(OP_SW, 0, 4, 12));       // stall on store data
    append_instr(2, {OP_HALT, 26'd0});
    expect_store(2, 32'd8, 32'h00000069);
    expect_store(2, 32'd12, 32'h0000abcd);
    test_name[3] = "branches";
    append_instr(3, itype_word(OP_ADDIU, 0, 1, 9));
    append_instr(3, itype_word(OP_ADDIU, 0, 2, 9));
    append_instr(3, itype_word(OP_BEQ, 1, 2, 2));       // taken to word 5
    append_instr(3, itype_word(OP_SW, 0, 1, 0));
    append_instr(3, itype_word(OP_SW, 0, 2, 4));
    append_instr(3, itype_word(OP_BNE, 1, 2, 1));       // not taken
    append_instr(3, itype_word(OP_SW, 0, 1, 8));
    append_instr(3, itype_word(OP_SW, 0, 2, 12));
    append_instr(3, {OP_HALT, 26'd0});
    expect_store(3, 32'd8, 32'd9);
    expect_store(3, 32'd12, 32'd9);
    test_name[4] = "jump_halt";
    append_instr(4, itype_word(OP_ADDIU, 0, 1, 16'h55));
    append_instr(4, jump_word(4));
    append_instr(4, itype_word(OP_SW, 0, 1, 0));
    append_instr(4, itype_word(OP_SW, 0, 1, 4));
    append_instr(4, itype_word(OP_SW, 0, 1, 8));
    append_instr(4, {OP_HALT, 26'd0});
    expect_store(4, 32'd8, 32'h55);
    // first program again with fetch gaps
    test_name[5] = "ihit_gaps";
    rand_gaps[5] = 1'b1;
    for (int i = 0; i < PW; i++) prog[5][i] = prog[0][i];
    for (int i = 0; i < exp_cnt[0]; i++) expect_store(5, exp_addr[0][i], exp_data[0][i]);
  endtask

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input string what, input word_t exp,
                            input word_t act);
    if (act !== exp) begin
      $display("ERROR %s: %s expected %h actual %h", name, what, exp, act);
      abort_run();
    end
  endtask

  task automatic check_count(input string name, input string what, input int exp,
                             input int act);
    if (act != exp) begin
      $display("ERROR %s: %s expected %0d actual %0d", name, what, exp, act);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input string what, input logic exp,
                           input logic act);
    if (act !== exp) begin
      $display("ERROR %s: %s expected %b actual %b", name, what, exp, act);
      abort_run();
    end
  endtask

  // memories load during reset and capture stores after it
  always @(posedge CLK) begin
    if (!nRST) begin
      for (int i = 0; i < 64; i++) begin
        imem[i] <= '0;
        dmem[i] <= '0;
      end
      for (int i = 0; i < PW; i++) imem[i] <= prog[cur][i];
      for (int i = 0; i < DW; i++) dmem[i] <= dinit[cur][i];
      seen_addr.delete();
      seen_data.delete();
    end else if (dmem_wen) begin
      dmem[dmem_addr[7:2]] <= dmem_store;
      seen_addr.push_back(dmem_addr);
      seen_data.push_back(dmem_store);
    end
  end

  always @(posedge CLK) begin
    if (rand_gaps[cur]) begin
      rng = xorshift(rng);
      ihit <= ((rng % 32'd3) != 32'd0);  // low about a third of cycles
    end else begin
      ihit <= 1'b1;
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * 10);
    $display("timeout: halt never came within %0d cycles", WATCHDOG_CYCLES);
    abort_run();
  end

  initial begin
    int n_at_halt;
    nRST = 1'b0;
    build_table();
    for (int t = 0; t < NT; t++) begin
      @(posedge CLK);
      cur <= t;
      nRST <= 1'b0;
      repeat (2) @(posedge CLK);
      nRST <= 1'b1;
      @(negedge CLK);
      check_word(test_name[t], "pc after reset", 32'h0, imem_addr);
      check_bit(test_name[t], "halt after reset", 1'b0, halt);
      check_bit(test_name[t], "dmem_wen after reset", 1'b0, dmem_wen);
      check_bit(test_name[t], "dmem_ren after reset", 1'b0, dmem_ren);
      while (halt !== 1'b1) @(negedge CLK);
      n_at_halt = seen_addr.size();
      repeat (8) begin
        @(negedge CLK);
        check_bit(test_name[t], "halt held", 1'b1, halt);
      end
      check_count(test_name[t], "stores after halt", n_at_halt, seen_addr.size());
      check_count(test_name[t], "store count", exp_cnt[t], seen_addr.size());
      for (int i = 0; i < exp_cnt[t]; i++) begin
        check_word(test_name[t], $sformatf("store %0d addr", i), exp_addr[t][i], seen_addr[i]);
        check_word(test_name[t], $sformatf("store %0d data", i), exp_data[t][i], seen_data[i]);
      end
    end
    $display("Simulation completed successfully");
    $finish;
  end

endmodule
